//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scaler_ctrl
SEED      ?= 85
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FILELIST  := verilog.f
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard logic/*.svh)
BIN       := $(BUILD_DIR)/V$(TOP)
PASS_MSG  := Finished with no errors

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) +verilator+seed+$(SEED) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_scaler_ctrl.sv
// Scaler control testbench
`include "scaler_config.svh"

module tb_scaler_ctrl;

	localparam int SEED                = 85;
	localparam int DRIVE_DLY           = 10;
	localparam int SCENARIOS           = 40;
	localparam int CYCLES_PER_SCENARIO = 400;
	localparam int TIMEOUT_CYCLES      = SCENARIOS * CYCLES_PER_SCENARIO;
	localparam int UPDATE_LIMIT        = 200;

	localparam logic [7:0] CODE_TIMING = 8'h20;
	localparam logic [7:0] CODE_VSET   = 8'h27;
	localparam logic [7:0] CODE_HSET   = 8'h37;
	localparam logic [7:0] CODE_ASPECT = 8'h3A;

	logic                 clk_sys = 1'b0;
	logic                 resetd;
	logic                 io_uio;
	logic                 io_strobe;
	logic [`SC_IO_W-1:0]  io_din;
	logic [`SC_AR_W-1:0]  arx;
	logic [`SC_AR_W-1:0]  ary;
	logic [`SC_DIM_W:0]   htotal;
	logic [`SC_DIM_W:0]   vtotal;
	logic                 hsync_neg;
	logic                 vsync_neg;
	logic [`SC_DIM_W-1:0] out_width;
	logic [`SC_DIM_W-1:0] out_height;
	logic [`SC_DIM_W-1:0] hmin;
	logic [`SC_DIM_W-1:0] hmax;
	logic [`SC_DIM_W-1:0] vmin;
	logic [`SC_DIM_W-1:0] vmax;
	logic                 geom_update;

	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;

	logic [15:0] frame_q[$];

	// Mirror of the configuration registers
	int m_width, m_hfp, m_hs, m_hbp, m_hs_neg;
	int m_height, m_vfp, m_vs, m_vbp, m_vs_neg;
	int m_vset, m_hset, m_freescale;
	int m_arc1x, m_arc1y, m_arc2x, m_arc2y;

	int e_htotal, e_vtotal, e_out_w, e_out_h;
	int e_hmin, e_hmax, e_vmin, e_vmax;

	scaler_ctrl_top u_scaler_ctrl_top (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_io_uio      (io_uio),
		.i_io_strobe   (io_strobe),
		.i_io_din      (io_din),
		.i_arx         (arx),
		.i_ary         (ary),
		.o_htotal      (htotal),
		.o_vtotal      (vtotal),
		.o_hsync_neg   (hsync_neg),
		.o_vsync_neg   (vsync_neg),
		.o_out_width   (out_width),
		.o_out_height  (out_height),
		.o_hmin        (hmin),
		.o_hmax        (hmax),
		.o_vmin        (vmin),
		.o_vmax        (vmax),
		.o_geom_update (geom_update)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped: no end of test after %0d cycles", cycle_count);
			error_count++;
			finish_run();
		end
	end

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host link

	task automatic send_word(input logic [15:0] word);
		io_din    = word;
		io_strobe = 1'b1;
		repeat (2) next_cycle();
		io_strobe = 1'b0;
		repeat (2) next_cycle();
	endtask

	task automatic send_frame(input logic [7:0] code);
		next_cycle();
		io_uio = 1'b1;
		next_cycle();
		send_word({8'h00, code});
		foreach (frame_q[i]) send_word(frame_q[i]);
		io_uio = 1'b0;
		repeat (2) next_cycle();
		frame_q.delete();
	endtask

	task automatic send_timing();
		int          v[8];
		int          extra;
		logic        neg_h;
		logic        neg_v;
		logic [15:0] word;
		v[0]  = $urandom_range(4095, 64);
		v[1]  = $urandom_range(255);
		v[2]  = $urandom_range(255, 1);
		v[3]  = $urandom_range(255);
		v[4]  = $urandom_range(4095, 64);
		v[5]  = $urandom_range(63);
		v[6]  = $urandom_range(15, 1);
		v[7]  = $urandom_range(63);
		neg_h = ($urandom_range(1) == 1);
		neg_v = ($urandom_range(1) == 1);
		extra = $urandom_range(3);
		for (int i = 0; i < 8; i++) begin
			// Junk in the upper bits except the polarity bit
			word       = 16'($urandom);
			word[11:0] = 12'(v[i]);
			if (i == 2) word[15] = neg_h;
			if (i == 6) word[15] = neg_v;
			frame_q.push_back(word);
		end
		repeat (extra) frame_q.push_back(16'($urandom));
		send_frame(CODE_TIMING);
		m_width  = v[0];
		m_hfp    = v[1];
		m_hs     = v[2];
		m_hbp    = v[3];
		m_height = v[4];
		m_vfp    = v[5];
		m_vs     = v[6];
		m_vbp    = v[7];
		m_hs_neg = int'(neg_h);
		m_vs_neg = int'(neg_v);
	endtask

	task automatic send_unknown();
		logic [7:0] code;
		code = 8'($urandom);
		while (code == CODE_TIMING || code == CODE_VSET || code == CODE_HSET ||
		       code == CODE_ASPECT) begin
			code = 8'($urandom);
		end
		repeat ($urandom_range(3, 1)) frame_q.push_back(16'($urandom));
		send_frame(code);
	endtask

	task automatic send_vset(input int v);
		frame_q.push_back({4'($urandom), 12'(v)});
		send_frame(CODE_VSET);
		m_vset = v;
	endtask

	task automatic send_hset(input logic fs, input int h);
		frame_q.push_back({fs, 3'($urandom), 12'(h)});
		send_frame(CODE_HSET);
		m_hset      = h;
		m_freescale = int'(fs);
	endtask

	task automatic send_aspect(input int a1x, input int a1y, input int a2x, input int a2y);
		frame_q.push_back({3'($urandom), 13'(a1x)});
		frame_q.push_back({3'($urandom), 13'(a1y)});
		frame_q.push_back({3'($urandom), 13'(a2x)});
		frame_q.push_back({3'($urandom), 13'(a2y)});
		send_frame(CODE_ASPECT);
		m_arc1x = a1x;
		m_arc1y = a1y;
		m_arc2x = a2x;
		m_arc2y = a2y;
	endtask

	task automatic set_request(input int x, input int y);
		next_cycle();
		arx = 13'(x);
		ary = 13'(y);
	endtask

	// Zero, below the limit, or anything
	function automatic int pick_override(input int limit);
		case ($urandom_range(3))
			0: return 0;
			1: return $urandom_range(limit - 1, 1);
			default: return $urandom_range(4095);
		endcase
	endfunction

	function automatic int pick_custom_aspect();
		case ($urandom_range(3))
			0: return 'h1000 | $urandom_range(4095);
			1: return 0;
			default: return $urandom_range(4095, 1);
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	task automatic reset_model();
		m_width  = 1920;
		m_hfp    = 88;
		m_hs     = 44;
		m_hbp    = 148;
		m_height = 1080;
		m_vfp    = 4;
		m_vs     = 5;
		m_vbp    = 36;
		m_hs_neg = 0;
		m_vs_neg = 0;
		m_vset = 0;
		m_hset = 0;
		m_freescale = 0;
		m_arc1x = 0;
		m_arc1y = 0;
		m_arc2x = 0;
		m_arc2y = 0;
	endtask

	task automatic compute_expected();
		int sx, sy, ax, ay, xy;
		int wcalc, hcalc, vw, vh;
		if (ary == 0) begin
			if (arx == 1) begin
				sx = m_arc1x;
				sy = m_arc1y;
			end else if (arx == 2) begin
				sx = m_arc2x;
				sy = m_arc2y;
			end else begin
				sx = 0;
				sy = 0;
			end
		end else begin
			sx = int'(arx);
			sy = int'(ary);
		end
		ax = sx & 'hfff;
		ay = sy & 'hfff;
		xy = ((sx | sy) >> 12) & 1;
		e_htotal = (m_width + m_hfp + m_hs + m_hbp) & 'h1fff;
		e_vtotal = (m_height + m_vfp + m_vs + m_vbp) & 'h1fff;
		e_out_w  = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		e_out_h  = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		if (m_freescale != 0 || ax == 0 || ay == 0) begin
			wcalc = e_out_w;
			hcalc = e_out_h;
		end else if (xy != 0) begin
			wcalc = ax;
			hcalc = ay;
		end else begin
			wcalc = ((e_out_h * ax) / ay) & 'hfff;
			hcalc = ((e_out_w * ay) / ax) & 'hfff;
		end
		vw = (wcalc > e_out_w) ? e_out_w : wcalc;
		vh = (hcalc > e_out_h) ? e_out_h : hcalc;
		e_hmin = ((m_width - vw) & 'hfff) >> 1;
		e_hmax = (e_hmin + vw - 1) & 'hfff;
		e_vmin = ((m_height - vh) & 'hfff) >> 1;
		e_vmax = (e_vmin + vh - 1) & 'hfff;
	endtask

	// Second pulse reflects the latest configuration
	task automatic wait_updates();
		int   seen;
		int   waited;
		logic was_high;
		seen     = 0;
		waited   = 0;
		was_high = 1'b0;
		while (seen < 2 && waited < UPDATE_LIMIT) begin
			@(negedge clk_sys);
			waited++;
			if (geom_update === 1'b1 && was_high) begin
				$display("Geometry update pulse stayed high for more than one cycle");
				error_count++;
			end else if (geom_update === 1'b1) begin
				seen++;
				waited = 0;
			end
			was_high = (geom_update === 1'b1);
		end
		if (seen < 2) begin
			$display("No geometry update pulse arrived within %0d cycles", UPDATE_LIMIT);
			error_count++;
		end
	endtask

	task automatic check_outputs(input string tag);
		compute_expected();
		check_value({tag, " htotal"}, e_htotal, htotal);
		check_value({tag, " vtotal"}, e_vtotal, vtotal);
		check_value({tag, " hsync_neg"}, m_hs_neg, hsync_neg);
		check_value({tag, " vsync_neg"}, m_vs_neg, vsync_neg);
		check_value({tag, " out_width"}, e_out_w, out_width);
		check_value({tag, " out_height"}, e_out_h, out_height);
		check_value({tag, " hmin"}, e_hmin, hmin);
		check_value({tag, " hmax"}, e_hmax, hmax);
		check_value({tag, " vmin"}, e_vmin, vmin);
		check_value({tag, " vmax"}, e_vmax, vmax);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Scenarios

	initial begin
		void'($urandom(SEED));
		resetd    = 1'b1;
		io_uio    = 1'b0;
		io_strobe = 1'b0;
		io_din    = '0;
		arx       = '0;
		ary       = '0;
		reset_model();
		repeat (3) @(posedge clk_sys);
		#DRIVE_DLY;
		resetd = 1'b0;

		wait_updates();
		check_outputs("reset");

		// Timing frames mixed with unknown commands
		repeat (8) begin
			if ($urandom_range(1) == 1) send_unknown();
			send_timing();
			if ($urandom_range(1) == 1) send_unknown();
			wait_updates();
			check_outputs("timing");
		end

		repeat (8) begin
			send_vset(pick_override(m_height));
			send_hset(1'b0, pick_override(m_width));
			wait_updates();
			check_outputs("override");
		end

		// Full window cases
		for (int i = 0; i < 4; i++) begin
			case (i)
				0: begin
					send_hset(1'b1, pick_override(m_width));
					set_request($urandom_range(4095, 1), $urandom_range(4095, 1));
				end
				1: begin
					send_hset(1'b0, pick_override(m_width));
					set_request($urandom_range(4095, 3), 0);
				end
				2: begin
					send_hset(1'b1, pick_override(m_width));
					set_request('h1000 | $urandom_range(4095), $urandom_range(4095, 1));
				end
				default: begin
					send_hset(1'b0, pick_override(m_width));
					set_request(0, $urandom_range(4095, 1));
				end
			endcase
			wait_updates();
			check_outputs("full window");
		end

		repeat (8) begin
			if ($urandom_range(1) == 1) send_timing();
			send_hset(1'b0, pick_override(m_width));
			set_request($urandom_range(4095, 1), $urandom_range(4095, 1));
			wait_updates();
			check_outputs("computed aspect");
		end

		// Literal requests, then custom ratios picked by ARX
		for (int i = 0; i < 8; i++) begin
			if (i < 3) begin
				set_request($urandom_range(4095) | ((i != 1) ? 'h1000 : 0),
				            $urandom_range(4095, 1) | ((i != 0) ? 'h1000 : 0));
			end else begin
				send_aspect(pick_custom_aspect(), pick_custom_aspect(),
				            pick_custom_aspect(), pick_custom_aspect());
				set_request(1 + (i % 2), 0);
			end
			wait_updates();
			check_outputs("literal aspect");
		end

		finish_run();
	end

endmodule

//--- logic/hps_cmd_decoder.sv
// Host command decoder
`include "scaler_config.svh"

module hps_cmd_decoder
	import scaler_pkg::*;
	import hps_io_pkg::*;
(
	input  logic     clk_sys,
	input  logic     resetd,
	input  logic     i_io_uio,
	input  logic     i_io_strobe,
	input  io_word_t i_io_din,
	video_cfg_if.src cfg
);

	logic        strobe_d;
	logic        strobe_q;
	logic        strobe_rise;
	logic        data_take;
	logic        has_cmd;
	io_cmd_e     cmd;
	logic  [7:0] word_cnt;

	dim_t        din_dim;
	sync_field_t din_sync;

	assign strobe_rise = strobe_d & ~strobe_q;
	assign data_take   = i_io_uio & strobe_rise & has_cmd;

	assign din_dim  = i_io_din[`SC_DIM_W-1:0];
	assign din_sync = '{neg: i_io_din[15], len: din_dim};

	////////////////////////////////////////////////////////////////////////////
	// Frame tracking

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			strobe_d <= 1'b0;
			strobe_q <= 1'b0;
			has_cmd  <= 1'b0;
			cmd      <= io_cmd_e'(8'h00);
			word_cnt <= '0;
		end else begin
			strobe_d <= i_io_strobe;
			strobe_q <= strobe_d;
			if (!i_io_uio) begin
				has_cmd <= 1'b0;
			end else if (strobe_rise) begin
				// First word carries the command code
				if (!has_cmd) begin
					has_cmd  <= 1'b1;
					cmd      <= io_cmd_e'(i_io_din[`SC_CMD_W-1:0]);
					word_cnt <= '0;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Configuration registers

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cfg.timing <= '{
				width:  `SC_DEF_WIDTH,
				hfp:    `SC_DEF_HFP,
				hs:     '{neg: `SC_DEF_HS_NEG, len: `SC_DEF_HS},
				hbp:    `SC_DEF_HBP,
				height: `SC_DEF_HEIGHT,
				vfp:    `SC_DEF_VFP,
				vs:     '{neg: `SC_DEF_VS_NEG, len: `SC_DEF_VS},
				vbp:    `SC_DEF_VBP
			};
			cfg.vset      <= '0;
			cfg.hset      <= '0;
			cfg.freescale <= 1'b0;
			cfg.arc1      <= '0;
			cfg.arc2      <= '0;
		end else if (data_take) begin
			case (cmd)
				CMD_VIDEO_TIMING: begin
					// Words past the eighth are ignored
					if (word_cnt < 8'd8) begin
						case (word_cnt[2:0])
							3'd0: cfg.timing.width  <= din_dim;
							3'd1: cfg.timing.hfp    <= din_dim;
							3'd2: cfg.timing.hs     <= din_sync;
							3'd3: cfg.timing.hbp    <= din_dim;
							3'd4: cfg.timing.height <= din_dim;
							3'd5: cfg.timing.vfp    <= din_dim;
							3'd6: cfg.timing.vs     <= din_sync;
							3'd7: cfg.timing.vbp    <= din_dim;
						endcase
					end
				end
				CMD_VSET: begin
					cfg.vset <= din_dim;
				end
				CMD_HSET: begin
					cfg.freescale <= i_io_din[15];
					cfg.hset      <= din_dim;
				end
				CMD_ASPECT: begin
					case (word_cnt)
						8'd0: cfg.arc1.x <= i_io_din[`SC_AR_W-1:0];
						8'd1: cfg.arc1.y <= i_io_din[`SC_AR_W-1:0];
						8'd2: cfg.arc2.x <= i_io_din[`SC_AR_W-1:0];
						8'd3: cfg.arc2.y <= i_io_din[`SC_AR_W-1:0];
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// Host frames stay short enough that the counter only climbs
	a_cnt_no_wrap: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(has_cmd && $past(has_cmd)) |-> (word_cnt >= $past(word_cnt))
	);

endmodule

//--- logic/hps_io_pkg.sv
// Host I/O link types
`include "scaler_config.svh"

package hps_io_pkg;

	// One word of the host link
	typedef logic [`SC_IO_W-1:0] io_word_t;

	// Command codes, first word of a frame
	typedef enum logic [`SC_CMD_W-1:0] {
		CMD_VIDEO_TIMING = 8'h20,
		CMD_VSET         = 8'h27,
		CMD_HSET         = 8'h37,
		CMD_ASPECT       = 8'h3A
	} io_cmd_e;

endpackage

//--- logic/scaler_config.svh
// Scaler control configuration
`ifndef SCALER_CONFIG_SVH
`define SCALER_CONFIG_SVH

// Field widths
`define SC_DIM_W       12
`define SC_AR_W        13
`define SC_IO_W        16
`define SC_CMD_W       8

// Multiply-divide operand width
`define SC_MD_W        12

// 1920x1080 reset timing
`define SC_DEF_WIDTH   12'd1920
`define SC_DEF_HFP     12'd88
`define SC_DEF_HS      12'd44
`define SC_DEF_HBP     12'd148
`define SC_DEF_HEIGHT  12'd1080
`define SC_DEF_VFP     12'd4
`define SC_DEF_VS      12'd5
`define SC_DEF_VBP     12'd36
`define SC_DEF_HS_NEG  1'b0
`define SC_DEF_VS_NEG  1'b0

`endif

//--- logic/scaler_ctrl_top.sv
// Scaler control top level
`include "scaler_config.svh"

module scaler_ctrl_top
	import scaler_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  logic                 i_io_uio,
	input  logic                 i_io_strobe,
	input  logic [`SC_IO_W-1:0]  i_io_din,
	input  logic [`SC_AR_W-1:0]  i_arx,
	input  logic [`SC_AR_W-1:0]  i_ary,
	output logic [`SC_DIM_W:0]   o_htotal,
	output logic [`SC_DIM_W:0]   o_vtotal,
	output logic                 o_hsync_neg,
	output logic                 o_vsync_neg,
	output logic [`SC_DIM_W-1:0] o_out_width,
	output logic [`SC_DIM_W-1:0] o_out_height,
	output logic [`SC_DIM_W-1:0] o_hmin,
	output logic [`SC_DIM_W-1:0] o_hmax,
	output logic [`SC_DIM_W-1:0] o_vmin,
	output logic [`SC_DIM_W-1:0] o_vmax,
	output logic                 o_geom_update
);

	window_t geom_window;

	video_cfg_if u_cfg ();

	hps_cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.cfg         (u_cfg.src)
	);

	scaler_geometry u_geometry (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_arx         (i_arx),
		.i_ary         (i_ary),
		.cfg           (u_cfg.dst),
		.o_htotal      (o_htotal),
		.o_vtotal      (o_vtotal),
		.o_hsync_neg   (o_hsync_neg),
		.o_vsync_neg   (o_vsync_neg),
		.o_out_width   (o_out_width),
		.o_out_height  (o_out_height),
		.o_window      (geom_window),
		.o_geom_update (o_geom_update)
	);

	// Window fields out as plain ports
	assign o_hmin = geom_window.hmin;
	assign o_hmax = geom_window.hmax;
	assign o_vmin = geom_window.vmin;
	assign o_vmax = geom_window.vmax;

endmodule

//--- logic/scaler_geometry.sv
// Scaler geometry engine
`include "scaler_config.svh"

module scaler_geometry
	import scaler_pkg::*;
(
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic [`SC_AR_W-1:0] i_arx,
	input  logic [`SC_AR_W-1:0] i_ary,
	video_cfg_if.dst            cfg,
	output logic [`SC_DIM_W:0]  o_htotal,
	output logic [`SC_DIM_W:0]  o_vtotal,
	output logic                o_hsync_neg,
	output logic                o_vsync_neg,
	output dim_t                o_out_width,
	output dim_t                o_out_height,
	output window_t             o_window,
	output logic                o_geom_update
);

	typedef logic [`SC_DIM_W:0] total_t;

	typedef enum logic [2:0] {
		S_SELECT,
		S_W_START,
		S_W_WAIT,
		S_H_START,
		S_H_WAIT,
		S_CLAMP,
		S_WINDOW
	} geom_state_e;

	geom_state_e state;

	dim_t    out_w;
	dim_t    out_h;
	aspect_t sel_ar;
	dim_t    sel_x;
	dim_t    sel_y;
	logic    sel_xy;
	logic    use_full;

	// Per-pass snapshot
	dim_t    width_l;
	dim_t    height_l;
	dim_t    out_w_l;
	dim_t    out_h_l;
	dim_t    ax_l;
	dim_t    ay_l;

	dim_t    wcalc;
	dim_t    hcalc;
	dim_t    videow;
	dim_t    videoh;
	dim_t    h_off;
	dim_t    v_off;

	logic                md_start;
	logic                md_busy;
	logic [`SC_MD_W-1:0] md_mul1;
	logic [`SC_MD_W-1:0] md_mul2;
	logic [`SC_MD_W-1:0] md_div;
	logic [`SC_MD_W-1:0] md_result;

	////////////////////////////////////////////////////////////////////////////
	// Totals and output size

	always_ff @(posedge clk_sys) begin
		o_htotal    <= total_t'(cfg.timing.width) + total_t'(cfg.timing.hfp) +
		               total_t'(cfg.timing.hbp) + total_t'(cfg.timing.hs.len);
		o_vtotal    <= total_t'(cfg.timing.height) + total_t'(cfg.timing.vfp) +
		               total_t'(cfg.timing.vbp) + total_t'(cfg.timing.vs.len);
		o_hsync_neg <= cfg.timing.hs.neg;
		o_vsync_neg <= cfg.timing.vs.neg;
	end

	// Override only when nonzero and smaller
	assign out_w = (cfg.hset != '0 && cfg.hset < cfg.timing.width) ?
	               cfg.hset : cfg.timing.width;
	assign out_h = (cfg.vset != '0 && cfg.vset < cfg.timing.height) ?
	               cfg.vset : cfg.timing.height;

	////////////////////////////////////////////////////////////////////////////
	// Aspect selection

	always_comb begin
		if (i_ary == '0) begin
			if (i_arx == `SC_AR_W'd1) begin
				sel_ar = cfg.arc1;
			end else if (i_arx == `SC_AR_W'd2) begin
				sel_ar = cfg.arc2;
			end else begin
				sel_ar = '0;
			end
		end else begin
			sel_ar = '{x: i_arx, y: i_ary};
		end
	end

	assign sel_x    = sel_ar.x[`SC_DIM_W-1:0];
	assign sel_y    = sel_ar.y[`SC_DIM_W-1:0];
	assign sel_xy   = sel_ar.x[`SC_AR_W-1] | sel_ar.y[`SC_AR_W-1];
	assign use_full = cfg.freescale || sel_x == '0 || sel_y == '0;

	assign h_off = (width_l - videow) >> 1;
	assign v_off = (height_l - videoh) >> 1;

	////////////////////////////////////////////////////////////////////////////
	// Window FSM

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state         <= S_SELECT;
			md_start      <= 1'b0;
			o_geom_update <= 1'b0;
			o_window      <= '0;
			o_out_width   <= '0;
			o_out_height  <= '0;
		end else begin
			md_start      <= 1'b0;
			o_geom_update <= 1'b0;
			case (state)
				S_SELECT: begin
					state <= (use_full || sel_xy) ? S_CLAMP : S_W_START;
				end
				S_W_START: begin
					md_start <= 1'b1;
					state    <= S_W_WAIT;
				end
				S_W_WAIT: begin
					if (!md_start && !md_busy) state <= S_H_START;
				end
				S_H_START: begin
					md_start <= 1'b1;
					state    <= S_H_WAIT;
				end
				S_H_WAIT: begin
					if (!md_start && !md_busy) state <= S_CLAMP;
				end
				S_CLAMP: begin
					state <= S_WINDOW;
				end
				S_WINDOW: begin
					o_window.hmin <= h_off;
					o_window.hmax <= h_off + videow - 1'b1;
					o_window.vmin <= v_off;
					o_window.vmax <= v_off + videoh - 1'b1;
					o_out_width   <= out_w_l;
					o_out_height  <= out_h_l;
					o_geom_update <= 1'b1;
					state         <= S_SELECT;
				end
				default: state <= S_SELECT;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		case (state)
			S_SELECT: begin
				width_l  <= cfg.timing.width;
				height_l <= cfg.timing.height;
				out_w_l  <= out_w;
				out_h_l  <= out_h;
				ax_l     <= sel_x;
				ay_l     <= sel_y;
				if (use_full) begin
					wcalc <= out_w;
					hcalc <= out_h;
				end else if (sel_xy) begin
					wcalc <= sel_x;
					hcalc <= sel_y;
				end
			end
			// Width from height
			S_W_START: begin
				md_mul1 <= out_h_l;
				md_mul2 <= ax_l;
				md_div  <= ay_l;
			end
			S_W_WAIT: wcalc <= md_result;
			// Height from width
			S_H_START: begin
				md_mul1 <= out_w_l;
				md_mul2 <= ay_l;
				md_div  <= ax_l;
			end
			S_H_WAIT: hcalc <= md_result;
			S_CLAMP: begin
				videow <= (wcalc > out_w_l) ? out_w_l : wcalc;
				videoh <= (hcalc > out_h_l) ? out_h_l : hcalc;
			end
			default: ;
		endcase
	end

	umuldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

endmodule

//--- logic/scaler_pkg.sv
// Scaler geometry types
`include "scaler_config.svh"

package scaler_pkg;

	// Pixel or line count
	typedef logic [`SC_DIM_W-1:0] dim_t;

	// Sync length with a negative polarity flag on top
	typedef struct packed {
		logic neg;
		dim_t len;
	} sync_field_t;

	typedef struct packed {
		dim_t        width;
		dim_t        hfp;
		sync_field_t hs;
		dim_t        hbp;
		dim_t        height;
		dim_t        vfp;
		sync_field_t vs;
		dim_t        vbp;
	} video_timing_t;

	// Top bit of each field marks a literal size
	typedef struct packed {
		logic [`SC_AR_W-1:0] x;
		logic [`SC_AR_W-1:0] y;
	} aspect_t;

	typedef struct packed {
		dim_t hmin;
		dim_t hmax;
		dim_t vmin;
		dim_t vmax;
	} window_t;

endpackage

//--- logic/umuldiv.sv
// Sequential multiply-divide unit
`include "scaler_config.svh"

module umuldiv (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_start,
	input  logic [`SC_MD_W-1:0] i_mul1,
	input  logic [`SC_MD_W-1:0] i_mul2,
	input  logic [`SC_MD_W-1:0] i_div,
	output logic                o_busy,
	output logic [`SC_MD_W-1:0] o_result
);

	localparam int W     = `SC_MD_W;
	localparam int STEPS = 2 * W;
	localparam int CNT_W = $clog2(STEPS + 1);

	typedef logic [2*W-1:0] prod_t;

	logic [CNT_W-1:0] step_cnt;
	prod_t            quo;
	logic [W-1:0]     rem;
	logic [W-1:0]     divisor;
	logic [W:0]       partial;
	logic [W:0]       trial;

	// Top bit of trial is the borrow of a restoring step
	assign partial  = {rem, quo[2*W-1]};
	assign trial    = partial - {1'b0, divisor};
	assign o_result = quo[W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy   <= 1'b0;
			step_cnt <= '0;
		end else if (i_start) begin
			o_busy   <= 1'b1;
			step_cnt <= CNT_W'(STEPS);
		end else if (o_busy) begin
			step_cnt <= step_cnt - 1'b1;
			if (step_cnt == CNT_W'(1)) begin
				o_busy <= 1'b0;
			end
		end
	end

	// Dividend shifts out as quotient bits shift in
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quo     <= prod_t'(i_mul1) * prod_t'(i_mul2);
			rem     <= '0;
			divisor <= i_div;
		end else if (o_busy) begin
			if (!trial[W]) begin
				rem <= trial[W-1:0];
				quo <= {quo[2*W-2:0], 1'b1};
			end else begin
				rem <= partial[W-1:0];
				quo <= {quo[2*W-2:0], 1'b0};
			end
		end
	end

	a_no_start_busy: assert property (
		@(posedge clk_sys) disable iff (resetd)
		i_start |-> !o_busy
	);

	a_div_nonzero: assert property (
		@(posedge clk_sys) disable iff (resetd)
		i_start |-> (i_div != '0)
	);

endmodule

//--- logic/video_cfg_if.sv
// Scaler configuration link
`include "scaler_config.svh"

interface video_cfg_if
	import scaler_pkg::*;
();

	video_timing_t timing;
	dim_t          vset;
	dim_t          hset;
	logic          freescale;
	aspect_t       arc1;
	aspect_t       arc2;

	// Command decoder side
	modport src (
		output timing, vset, hset, freescale, arc1, arc2
	);

	// Geometry engine side
	modport dst (
		input  timing, vset, hset, freescale, arc1, arc2
	);

endinterface

//--- verilog.f
+incdir+logic
logic/scaler_pkg.sv
logic/hps_io_pkg.sv
logic/video_cfg_if.sv
logic/hps_cmd_decoder.sv
logic/umuldiv.sv
logic/scaler_geometry.sv
logic/scaler_ctrl_top.sv
bench/tb_scaler_ctrl.sv
